/* logic/vga_defines.svh */
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

//////////////////////////////
// Screen geometry
//////////////////////////////

// Small simulation mode, 16x8 visible
// Full 1280x1024 mode uses:
//   HD 1280, HF 48, HR 112, HB 248
//   VD 1024, VF 1,  VR 3,   VB 38
//   X_BITS 11, Y_BITS 10, COUNT_BITS 11

`define VGA_HD 16  // Display width, pixels
`define VGA_HF 2   // Front porch
`define VGA_HR 3   // Sync pulse
`define VGA_HB 3   // Back porch

`define VGA_VD 8   // Display height, lines
`define VGA_VF 1
`define VGA_VR 1
`define VGA_VB 2

`define VGA_HTOTAL (`VGA_HD + `VGA_HF + `VGA_HR + `VGA_HB)
`define VGA_VTOTAL (`VGA_VD + `VGA_VF + `VGA_VR + `VGA_VB)

// Widths
`define VGA_X_BITS      4
`define VGA_Y_BITS      3
`define VGA_COUNT_BITS  11
`define VGA_FB_DEPTH    (`VGA_HD * `VGA_VD)
`define VGA_WB_ADR_BITS (`VGA_X_BITS + `VGA_Y_BITS)  // y above x
`define VGA_WB_DAT_BITS 8

`endif

/* logic/vga_pkg.sv */
`include "vga_defines.svh"

package vga_pkg;

  // Plain vector types
  typedef logic [`VGA_X_BITS-1:0]             coord_x_t;
  typedef logic [`VGA_Y_BITS-1:0]             coord_y_t;
  typedef logic [`VGA_COUNT_BITS-1:0]         count_t;    // Raw scan counter
  typedef logic [1:0]                         pix_idx_t;
  typedef logic [11:0]                        rgb_t;      // 4 bits each of R, G, B
  typedef logic [$clog2(`VGA_FB_DEPTH)-1:0]   fb_addr_t;

  // Palette entries, index order is fixed
  typedef enum pix_idx_t {
    COLOR_BLACK,
    COLOR_WHITE,
    COLOR_BLUE,
    COLOR_GREEN
  } color_e;

  // Scan position and sync, travels down the pipeline
  typedef struct packed {
    logic     hsync;
    logic     vsync;
    logic     active;
    coord_x_t x;
    coord_y_t y;
  } beam_t;

  typedef struct packed {
    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [`VGA_WB_ADR_BITS-1:0]   adr;
    logic [`VGA_WB_DAT_BITS-1:0]   dat;
  } wb_req_t;

  typedef struct packed {
    logic                          ack;
    logic [`VGA_WB_DAT_BITS-1:0]   dat;
  } wb_rsp_t;

endpackage

/* logic/video_timing.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module video_timing (
  input  logic           clk,
  input  logic           arstn,
  output vga_pkg::beam_t beam
);

  localparam int H_START = `VGA_HR + `VGA_HB;  // First visible column
  localparam int V_START = `VGA_VR + `VGA_VB;  // First visible line

  vga_pkg::count_t hcnt;
  vga_pkg::count_t vcnt;
  vga_pkg::count_t hoff;
  vga_pkg::count_t voff;
  logic            h_last;
  logic            v_last;
  logic            h_vis;
  logic            v_vis;

  assign h_last = (hcnt == vga_pkg::count_t'(`VGA_HTOTAL - 1));
  assign v_last = (vcnt == vga_pkg::count_t'(`VGA_VTOTAL - 1));

  //////////////////////////////
  // Scan counters
  //////////////////////////////

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      hcnt <= '0;
    end else if (h_last) begin
      hcnt <= '0;
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // Steps once per line
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      vcnt <= '0;
    end else if (h_last) begin
      if (v_last) begin
        vcnt <= '0;
      end else begin
        vcnt <= vcnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Beam register
  //////////////////////////////

  assign hoff  = hcnt - vga_pkg::count_t'(H_START);
  assign voff  = vcnt - vga_pkg::count_t'(V_START);
  assign h_vis = (hcnt >= H_START) && (hcnt < H_START + `VGA_HD);
  assign v_vis = (vcnt >= V_START) && (vcnt < V_START + `VGA_VD);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      beam <= '0;
    end else begin
      beam.hsync  <= (hcnt < `VGA_HR);
      beam.vsync  <= (vcnt < `VGA_VR);
      beam.active <= h_vis && v_vis;
      beam.x      <= hoff[`VGA_X_BITS-1:0];  // Only meaningful while active
      beam.y      <= voff[`VGA_Y_BITS-1:0];
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (!arstn)
    (hcnt < `VGA_HTOTAL) && (vcnt < `VGA_VTOTAL));

  // Visible area lies clear of both sync pulses
  a_active_pos: assert property (@(posedge clk) disable iff (!arstn)
    beam.active |-> (beam.x < `VGA_HD) && !beam.hsync && !beam.vsync);

endmodule

/* logic/frame_buffer.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module frame_buffer (
  input  logic              clk,
  input  logic              arstn,
  // Bus side
  input  logic              we,
  input  vga_pkg::fb_addr_t waddr,
  input  vga_pkg::pix_idx_t wdata,
  input  vga_pkg::fb_addr_t raddr,
  output vga_pkg::pix_idx_t rdata,
  // Video side
  input  vga_pkg::beam_t    beam_in,
  output vga_pkg::beam_t    beam_out,
  output vga_pkg::pix_idx_t pix
);

  vga_pkg::pix_idx_t mem [`VGA_FB_DEPTH];
  vga_pkg::fb_addr_t vaddr;

  //////////////////////////////
  // Bus port
  //////////////////////////////

  // Read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  //////////////////////////////
  // Video port
  //////////////////////////////

  // Row-major, blanking reads park at zero
  assign vaddr = beam_in.active ?
                 vga_pkg::fb_addr_t'(beam_in.y * `VGA_HD + beam_in.x) : '0;

  always_ff @(posedge clk) begin
    pix <= mem[vaddr];
  end

  // Beam follows the read by one stage
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      beam_out <= '0;
    end else begin
      beam_out <= beam_in;
    end
  end

endmodule

/* logic/wb_pixel_port.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module wb_pixel_port (
  input  logic              clk,
  input  logic              arstn,
  input  vga_pkg::wb_req_t  wb_req,
  output vga_pkg::wb_rsp_t  wb_rsp,
  output logic              fb_we,
  output vga_pkg::fb_addr_t fb_waddr,
  output vga_pkg::fb_addr_t fb_raddr,
  output vga_pkg::pix_idx_t fb_wdata,
  input  vga_pkg::pix_idx_t fb_rdata
);

  vga_pkg::coord_x_t x;
  vga_pkg::coord_y_t y;
  vga_pkg::fb_addr_t lin_addr;
  logic              in_range;
  logic              access;
  logic              ack_q;
  logic              oor_q;  // Last access was off screen

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign x        = wb_req.adr[`VGA_X_BITS-1:0];
  assign y        = wb_req.adr[`VGA_X_BITS +: `VGA_Y_BITS];
  assign in_range = (x < `VGA_HD) && (y < `VGA_VD);
  assign lin_addr = vga_pkg::fb_addr_t'(y * `VGA_HD + x);

  // Strobe seen while no ack pending
  assign access = wb_req.cyc && wb_req.stb && !ack_q;

  assign fb_we    = access && wb_req.we && in_range;
  assign fb_waddr = lin_addr;
  assign fb_raddr = lin_addr;
  assign fb_wdata = wb_req.dat[1:0];

  //////////////////////////////
  // Handshake
  //////////////////////////////

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      oor_q <= !in_range;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = (ack_q && !oor_q) ?
                      {{(`VGA_WB_DAT_BITS-2){1'b0}}, fb_rdata} : '0;

  a_ack_single: assert property (@(posedge clk) disable iff (!arstn)
    ack_q |=> !ack_q);

  a_ack_after_stb: assert property (@(posedge clk) disable iff (!arstn)
    ack_q |-> $past(wb_req.cyc && wb_req.stb));

endmodule

/* logic/color_palette.sv */
`timescale 1ns/1ps

module color_palette (
  input  logic              clk,
  input  logic              arstn,
  input  vga_pkg::beam_t    beam,
  input  vga_pkg::pix_idx_t pix,
  output logic              hsync,
  output logic              vsync,
  output vga_pkg::rgb_t     rgb
);

  vga_pkg::rgb_t color;
  vga_pkg::rgb_t rgb_next;

  //////////////////////////////
  // Palette lookup
  //////////////////////////////

  always_comb begin
    case (vga_pkg::color_e'(pix))
      vga_pkg::COLOR_BLACK: color = 12'h000;
      vga_pkg::COLOR_WHITE: color = 12'hfff;
      vga_pkg::COLOR_BLUE:  color = 12'hf00;  // Top nibble
      vga_pkg::COLOR_GREEN: color = 12'h0f0;  // Middle nibble
      default:              color = 12'h000;
    endcase
  end

  // Blank outside the visible area
  assign rgb_next = beam.active ? color : '0;

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Sync and colour leave on the same edge
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end else begin
      hsync <= beam.hsync;
      vsync <= beam.vsync;
      rgb   <= rgb_next;
    end
  end

endmodule

/* logic/vga_display_top.sv */
`timescale 1ns/1ps

module vga_display_top (
  input  logic             clk,
  input  logic             arstn,
  input  vga_pkg::wb_req_t wb_req,
  output vga_pkg::wb_rsp_t wb_rsp,
  output logic             hsync,
  output logic             vsync,
  output vga_pkg::rgb_t    rgb
);

  // Bus port to buffer
  logic              fb_we;
  vga_pkg::fb_addr_t fb_waddr;
  vga_pkg::fb_addr_t fb_raddr;
  vga_pkg::pix_idx_t fb_wdata;
  vga_pkg::pix_idx_t fb_rdata;

  // Video pipeline
  vga_pkg::beam_t    beam_t0;  // Timing stage out
  vga_pkg::beam_t    beam_t1;  // Buffer stage out
  vga_pkg::pix_idx_t pix;

  wb_pixel_port u_wb_port (
    .clk      (clk),
    .arstn    (arstn),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_raddr (fb_raddr),
    .fb_wdata (fb_wdata),
    .fb_rdata (fb_rdata)
  );

  video_timing u_timing (
    .clk   (clk),
    .arstn (arstn),
    .beam  (beam_t0)
  );

  frame_buffer u_fb (
    .clk      (clk),
    .arstn    (arstn),
    .we       (fb_we),
    .waddr    (fb_waddr),
    .wdata    (fb_wdata),
    .raddr    (fb_raddr),
    .rdata    (fb_rdata),
    .beam_in  (beam_t0),
    .beam_out (beam_t1),
    .pix      (pix)
  );

  color_palette u_palette (
    .clk   (clk),
    .arstn (arstn),
    .beam  (beam_t1),
    .pix   (pix),
    .hsync (hsync),
    .vsync (vsync),
    .rgb   (rgb)
  );

endmodule

/* verification/vga_clk_gen.sv */
`timescale 1ns/1ps

module vga_clk_gen (
  output logic clk,
  output logic arstn
);

  localparam int HALF_NS = 10;  // 20 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // Held for 8 rising edges, released between edges
  initial begin
    arstn = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstn = 1'b1;
  end

endmodule

/* verification/vga_display_tb.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"

module vga_display_tb;

  localparam int TRACE_LEN    = 64;
  localparam int ACK_TIMEOUT  = 8;
  localparam int RST_TIMEOUT  = 20;
  localparam int FRAME_CYC    = `VGA_HTOTAL * `VGA_VTOTAL;
  localparam int SYNC_TIMEOUT = 2 * FRAME_CYC;

  logic             clk;
  logic             arstn;
  vga_pkg::wb_req_t wb_req;
  vga_pkg::wb_rsp_t wb_rsp;
  logic             hsync;
  logic             vsync;
  vga_pkg::rgb_t    rgb;

  logic [31:0]       trace [TRACE_LEN];
  logic [1:0]        model [`VGA_FB_DEPTH];  // Expected screen content
  int                checks;
  int                errors;

  vga_clk_gen u_clk_gen (
    .clk   (clk),
    .arstn (arstn)
  );

  vga_display_top u_dut (
    .clk    (clk),
    .arstn  (arstn),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .hsync  (hsync),
    .vsync  (vsync),
    .rgb    (rgb)
  );

  //////////////////////////////
  // Reference values
  //////////////////////////////

  function automatic logic [11:0] palette_rgb(input logic [1:0] idx);
    case (idx)
      2'd1:    return 12'hfff;  // White
      2'd2:    return 12'hf00;  // Blue is the top nibble
      2'd3:    return 12'h0f0;  // Green
      default: return 12'h000;
    endcase
  endfunction

  // Every x and y bit feeds the index
  function automatic logic [1:0] fill_idx(input int x, input int y, input logic [1:0] seed);
    int mix;
    mix = x ^ (x >> 2) ^ y ^ (y >> 2);
    return mix[1:0] ^ seed;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s expected %0h got %0h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic sample_edge;
    @(posedge clk);
    #1;  // Outputs settled and inputs change here
  endtask

  task automatic check_idle_outputs;
    compare_value("wb_rsp.ack", 0, wb_rsp.ack);
    compare_value("hsync", 0, hsync);
    compare_value("vsync", 0, vsync);
    compare_value("rgb", 0, rgb);
  endtask

  //////////////////////////////
  // Wishbone driver
  //////////////////////////////

  task automatic wb_access(input logic we, input int x, input int y,
                           input logic [7:0] wdat, output logic [7:0] rdat);
    int waited;
    compare_value("wb_rsp.ack", 0, wb_rsp.ack);  // No ack before stb
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = {y[`VGA_Y_BITS-1:0], x[`VGA_X_BITS-1:0]};
    wb_req.dat = wdat;
    rdat       = '0;
    waited     = 0;
    do begin
      sample_edge();
      waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (!wb_rsp.ack) begin
      $display("Timeout: no Wishbone ack at %0t", $time);
      errors++;
    end else begin
      compare_value("ack_latency", 1, waited);
      rdat = wb_rsp.dat;
    end
    wb_req = '0;
    sample_edge();
    compare_value("wb_rsp.ack", 0, wb_rsp.ack);  // Single ack cycle
  endtask

  // Off-screen writes are dropped and off-screen reads give zero
  task automatic write_pixel(input int x, input int y, input logic [7:0] data);
    int         xa;
    int         ya;
    logic [7:0] unused;
    xa = x % (1 << `VGA_X_BITS);  // Field wider than the bus address
    ya = y % (1 << `VGA_Y_BITS);
    wb_access(1'b1, xa, ya, data, unused);
    if (xa < `VGA_HD && ya < `VGA_VD) model[ya * `VGA_HD + xa] = data[1:0];
  endtask

  task automatic read_pixel(input int x, input int y, input logic [7:0] exp);
    int         xa;
    int         ya;
    logic [7:0] rdat;
    xa = x % (1 << `VGA_X_BITS);
    ya = y % (1 << `VGA_Y_BITS);
    wb_access(1'b0, xa, ya, 8'h00, rdat);
    compare_value("wb_rsp.dat", (xa < `VGA_HD && ya < `VGA_VD) ? exp : 8'h00, rdat);
  endtask

  task automatic fill_screen(input logic [1:0] seed);
    for (int y = 0; y < `VGA_VD; y++) begin
      for (int x = 0; x < `VGA_HD; x++) begin
        write_pixel(x, y, {6'd0, fill_idx(x, y, seed)});
      end
    end
  endtask

  //////////////////////////////
  // Screen monitor
  //////////////////////////////

  task automatic find_frame_start(output bit found);
    int waited;
    waited = 0;
    while (vsync && waited < SYNC_TIMEOUT) begin
      sample_edge();
      waited++;
    end
    while (!vsync && waited < SYNC_TIMEOUT) begin
      sample_edge();
      waited++;
    end
    found = vsync && (waited < SYNC_TIMEOUT);
    if (!found) begin
      $display("Timeout: vsync never started a frame");
      errors++;
    end
  endtask

  task automatic check_frame;
    bit          found;
    bit          active;
    bit          seen [4];
    int          line;
    int          col;
    int          x;
    int          y;
    logic [11:0] exp_rgb;
    find_frame_start(found);
    if (found) begin
      seen = '{default: 1'b0};
      for (int n = 0; n < FRAME_CYC; n++) begin
        if (n != 0) sample_edge();
        line    = n / `VGA_HTOTAL;
        col     = n % `VGA_HTOTAL;
        x       = col - (`VGA_HR + `VGA_HB);
        y       = line - (`VGA_VR + `VGA_VB);
        active  = (x >= 0) && (x < `VGA_HD) && (y >= 0) && (y < `VGA_VD);
        exp_rgb = active ? palette_rgb(model[y * `VGA_HD + x]) : 12'h000;
        compare_value("hsync", col < `VGA_HR, hsync);
        compare_value("vsync", line < `VGA_VR, vsync);
        compare_value("rgb", exp_rgb, rgb);
        // Entries as they show on the screen
        if (active) begin
          for (int i = 0; i < 4; i++) begin
            if (rgb === palette_rgb(i[1:0])) seen[i] = 1'b1;
          end
        end
      end
      sample_edge();
      compare_value("vsync", 1, vsync);  // Next frame right on time
      compare_value("hsync", 1, hsync);
      for (int i = 0; i < 4; i++) begin
        if (!seen[i]) begin
          $display("Palette entry %0d never appeared in the frame", i);
          errors++;
        end
      end
    end
  endtask

  //////////////////////////////
  // Trace player
  //////////////////////////////

  initial begin
    logic [31:0] rec;
    int          waited;
    int          pos;
    bit          done;
    wb_req = '0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < TRACE_LEN; i++) trace[i] = '0;  // Zero opcode ends the run
    $readmemh("verification/vga_trace.hex", trace);

    waited = 0;
    sample_edge();
    while (!arstn && waited < RST_TIMEOUT) begin
      check_idle_outputs();
      sample_edge();
      waited++;
    end
    if (!arstn) begin
      $display("Timeout: reset never released");
      errors++;
    end else begin
      check_idle_outputs();  // First edge after release
    end

    pos  = 0;
    done = 1'b0;
    while (!done && pos < TRACE_LEN) begin
      rec = trace[pos];
      case (rec[31:28])
        4'h0: done = 1'b1;
        4'h1: write_pixel(rec[19:12], rec[27:20], rec[7:0]);
        4'h2: read_pixel(rec[19:12], rec[27:20], rec[7:0]);
        4'h3: check_frame();
        4'h4: fill_screen(rec[1:0]);
        default: begin
          $display("Unknown opcode in trace record %0d", pos);
          errors++;
        end
      endcase
      pos++;
    end

    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+logic
logic/vga_pkg.sv
logic/video_timing.sv
logic/frame_buffer.sv
logic/wb_pixel_port.sv
logic/color_palette.sv
logic/vga_display_top.sv
verification/vga_clk_gen.sv
verification/vga_display_tb.sv

/* verification/vga_trace.hex */
// One record per word: op[31:28] y[27:20] x[19:12] unused[11:8] data[7:0]
// op 1 write, 2 read and expect data, 3 check a frame, 4 fill with seed, 0 end
40000000  // Fill, seed 0
30000000
20102003  // Fill pattern at y1 x2
20609000  // Fill pattern at y6 x9
10305002
20305002
1000F003
2000F003
10707001
20707001
10700000
20700000
102010FF  // Upper data bits ignored
20201003
30000000
40000001  // Fill, seed 1
20000001
30000000
00000000
